//--- hdl/usb_bridge_pkg.sv
`default_nettype none

package usb_bridge_pkg;

    // opcode byte of a host command.
    typedef enum logic [7:0] {
        op_write   = 8'h01,
        op_read    = 8'h02,
        op_capture = 8'h03
    } cmd_op_t;

    // one access on the shared memory port, 17 bits.
    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [7:0] wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        rx_idle,
        rx_assert_rd,
        rx_wait_1,
        rx_wait_2,
        rx_offer,
        rx_flush_1,
        rx_flush_2
    } rx_state_t;

    typedef enum logic [2:0] {
        dec_op,
        dec_addr,
        dec_data,
        dec_req
    } dec_state_t;

endpackage

`default_nettype wire

//--- hdl/usb_fifo_rx.sv
`timescale 1ns/1ps
`default_nettype none

module usb_fifo_rx
    import usb_bridge_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rxf_n,
    output logic            rd_n,
    input  wire logic [7:0] fifo_data,
    output logic            byte_valid,
    input  wire logic       byte_ack,
    output logic [7:0]      byte_data
);

    logic       rxf_n_d1;
    logic       rxf_n_d2;
    logic [7:0] data_d1;
    logic [7:0] data_d2;
    rx_state_t  state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxf_n_d1 <= 1'b1; // flag idles high.
            rxf_n_d2 <= 1'b1;
        end else begin
            rxf_n_d1 <= rxf_n;
            rxf_n_d2 <= rxf_n_d1;
        end
    end

    always_ff @(posedge clk) begin
        data_d1 <= fifo_data;
        data_d2 <= data_d1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rx_idle;
            rd_n  <= 1'b1;
        end else begin
            case (state)
                rx_idle: begin
                    if (!rxf_n_d2) begin
                        state <= rx_assert_rd;
                        rd_n  <= 1'b0;
                    end
                end
                rx_assert_rd: state <= rx_wait_1;
                rx_wait_1:    state <= rx_wait_2; // let the data settle through sync.
                rx_wait_2:    state <= rx_offer;
                rx_offer: begin
                    if (byte_ack) begin
                        state <= rx_flush_1;
                        rd_n  <= 1'b1;
                    end
                end
                // the flag sync still shows the old level for two cycles.
                rx_flush_1:   state <= rx_flush_2;
                rx_flush_2:   state <= rx_idle;
                default:      state <= rx_idle;
            endcase
        end
    end

    assign byte_valid = (state == rx_offer);
    assign byte_data  = data_d2;

    a_ack_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) byte_ack |-> byte_valid
    );

endmodule

`default_nettype wire

//--- hdl/cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import usb_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       byte_valid,
    input  wire logic [7:0] byte_data,
    output logic            byte_ack,
    output logic            req,
    input  wire logic       gnt,
    output mem_req_t        mem_req,
    input  wire logic [7:0] rdata,
    output logic            rsp_valid,
    output logic [7:0]      rsp_data,
    output logic            cap_start,
    output logic [7:0]      cap_addr,
    output logic [7:0]      cap_count
);

    localparam logic [7:0] ADDR_MASK = 8'((1 << ADDR_W) - 1);

    dec_state_t state;
    cmd_op_t    op_q;
    logic [7:0] addr_q;
    logic [7:0] rsp_hold;

    // no ack while a memory request is outstanding.
    assign byte_ack = byte_valid && (state != dec_req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= dec_op;
            req       <= 1'b0;
            rsp_valid <= 1'b0;
            cap_start <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            cap_start <= 1'b0;
            case (state)
                dec_op:   if (byte_ack) state <= dec_addr;
                dec_addr: if (byte_ack) state <= dec_data;
                dec_data: begin
                    if (byte_ack) begin
                        state <= dec_op;
                        case (op_q)
                            op_write, op_read: begin
                                state <= dec_req;
                                req   <= 1'b1;
                            end
                            op_capture: cap_start <= 1'b1;
                            default: ; // unknown opcode, dropped.
                        endcase
                    end
                end
                dec_req: begin
                    if (gnt) begin
                        state     <= dec_op;
                        req       <= 1'b0;
                        rsp_valid <= !mem_req.we; // rdata lands next cycle.
                    end
                end
                default: state <= dec_op;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (byte_ack && state == dec_op)
            op_q <= cmd_op_t'(byte_data);
        if (byte_ack && state == dec_addr)
            addr_q <= byte_data & ADDR_MASK;
        if (byte_ack && state == dec_data) begin
            mem_req.we    <= (op_q == op_write);
            mem_req.addr  <= addr_q;
            mem_req.wdata <= byte_data;
            cap_addr      <= addr_q;
            cap_count     <= byte_data;
        end
        if (rsp_valid)
            rsp_hold <= rdata;
    end

    // hold the last response after the pulse.
    assign rsp_data = rsp_valid ? rdata : rsp_hold;

endmodule

`default_nettype wire

//--- hdl/capture_engine.sv
`timescale 1ns/1ps
`default_nettype none

module capture_engine
    import usb_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       cap_start,
    input  wire logic [7:0] cap_addr,
    input  wire logic [7:0] cap_count,
    input  wire logic       sample_strobe,
    input  wire logic [7:0] sample_data,
    output logic            req,
    input  wire logic       gnt,
    output mem_req_t        mem_req,
    output logic            cap_busy,
    output logic            cap_overrun
);

    localparam logic [7:0] ADDR_MASK = 8'((1 << ADDR_W) - 1);

    logic [7:0] next_addr;
    logic [7:0] left; // samples still to accept.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req         <= 1'b0;
            cap_busy    <= 1'b0;
            cap_overrun <= 1'b0;
            left        <= 8'd0;
            next_addr   <= 8'd0;
        end else if (cap_start) begin
            cap_busy  <= (cap_count != 8'd0); // a count of 0 captures nothing.
            left      <= cap_count;
            next_addr <= cap_addr & ADDR_MASK;
            req       <= 1'b0;
        end else if (cap_busy) begin
            if (req && gnt) begin
                req <= 1'b0;
                if (left == 8'd0)
                    cap_busy <= 1'b0;
            end
            if (sample_strobe) begin
                if (req && !gnt) begin
                    cap_overrun <= 1'b1; // previous write still waiting.
                end else if (left != 8'd0) begin
                    req       <= 1'b1;
                    left      <= left - 8'd1;
                    next_addr <= (next_addr + 8'd1) & ADDR_MASK;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cap_busy && sample_strobe && (!req || gnt) && left != 8'd0)
            mem_req <= '{we: 1'b1, addr: next_addr, wdata: sample_data};
    end

    a_req_only_busy: assert property (
        @(posedge clk) disable iff (!rst_n) req |-> cap_busy
    );

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import usb_bridge_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     dec_req,
    input  wire mem_req_t dec_mem,
    output logic          dec_gnt,
    input  wire logic     cap_req,
    input  wire mem_req_t cap_mem,
    output logic          cap_gnt,
    output logic          ram_en,
    output mem_req_t      ram_mem
);

    logic last_cap; // capture engine was served last.

    always_comb begin
        dec_gnt = 1'b0;
        cap_gnt = 1'b0;
        if (dec_req && cap_req) begin
            dec_gnt = last_cap;
            cap_gnt = !last_cap;
        end else begin
            dec_gnt = dec_req;
            cap_gnt = cap_req;
        end
    end

    assign ram_en  = dec_gnt || cap_gnt;
    assign ram_mem = cap_gnt ? cap_mem : dec_mem;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_cap <= 1'b0;
        else if (ram_en)
            last_cap <= cap_gnt;
    end

    // a requester that just got served must not win again while the other waits.
    a_fair: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cap_gnt && dec_req) |=> !(cap_gnt && dec_req)
    );

    a_one_grant: assert property (
        @(posedge clk) disable iff (!rst_n) !(dec_gnt && cap_gnt)
    );

endmodule

`default_nettype wire

//--- hdl/shared_ram.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram
    import usb_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  wire logic     clk,
    input  wire logic     ram_en,
    input  wire mem_req_t ram_mem,
    output logic [7:0]    rdata
);

    logic [7:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_mem.we)
                mem[ram_mem.addr[ADDR_W-1:0]] <= ram_mem.wdata;
            rdata <= mem[ram_mem.addr[ADDR_W-1:0]]; // read first.
        end
    end

endmodule

`default_nettype wire

//--- hdl/usb_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module usb_cmd_bridge
    import usb_bridge_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       rxf_n,
    output logic            rd_n,
    input  wire logic [7:0] fifo_data,
    input  wire logic       sample_strobe,
    input  wire logic [7:0] sample_data,
    output logic            rsp_valid,
    output logic [7:0]      rsp_data,
    output logic            cap_busy,
    output logic            cap_overrun
);

    logic       byte_valid;
    logic       byte_ack;
    logic [7:0] byte_data;
    logic       dec_req;
    logic       dec_gnt;
    mem_req_t   dec_mem;
    logic       cap_req;
    logic       cap_gnt;
    mem_req_t   cap_mem;
    logic       ram_en;
    mem_req_t   ram_mem;
    logic [7:0] rdata;
    logic       cap_start;
    logic [7:0] cap_addr;
    logic [7:0] cap_count;

    usb_fifo_rx u_usb_fifo_rx (
        .clk, .rst_n, .rxf_n, .rd_n, .fifo_data,
        .byte_valid, .byte_ack, .byte_data
    );

    cmd_decoder #(.ADDR_W(ADDR_W)) u_cmd_decoder (
        .clk, .rst_n, .byte_valid, .byte_data, .byte_ack,
        .req(dec_req), .gnt(dec_gnt), .mem_req(dec_mem), .rdata,
        .rsp_valid, .rsp_data, .cap_start, .cap_addr, .cap_count
    );

    capture_engine #(.ADDR_W(ADDR_W)) u_capture_engine (
        .clk, .rst_n, .cap_start, .cap_addr, .cap_count,
        .sample_strobe, .sample_data,
        .req(cap_req), .gnt(cap_gnt), .mem_req(cap_mem), .cap_busy, .cap_overrun
    );

    mem_arbiter u_mem_arbiter (
        .clk, .rst_n, .dec_req, .dec_mem, .dec_gnt,
        .cap_req, .cap_mem, .cap_gnt, .ram_en, .ram_mem
    );

    shared_ram #(.ADDR_W(ADDR_W)) u_shared_ram (
        .clk, .ram_en, .ram_mem, .rdata
    );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (4) @(negedge clk); // release away from the rising edge.
        rst_n = 1'b1;
    end

    always #10 clk = ~clk;

endmodule

`default_nettype wire

//--- bench/tb_usb_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_cmd_bridge
    import usb_bridge_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       rxf_n;
    logic       rd_n;
    logic [7:0] fifo_data;
    logic       sample_strobe;
    logic [7:0] sample_data;
    logic       rsp_valid;
    logic [7:0] rsp_data;
    logic       cap_busy;
    logic       cap_overrun;

    logic [7:0] fifo_q[$];      // bytes held by the FIFO chip.
    logic [7:0] exp_q[$];       // expected read responses in command order.
    logic [7:0] ref_mem [256];
    logic [7:0] used_addr[$];
    logic [7:0] want;
    logic       rd_n_q;
    int         errors;
    int         checks;
    int         mark;
    int         failed_tests;

    clk_gen u_clk_gen (.clk, .rst_n);

    usb_cmd_bridge #(.ADDR_W(8)) u_usb_cmd_bridge (
        .clk, .rst_n, .rxf_n, .rd_n, .fifo_data, .sample_strobe, .sample_data,
        .rsp_valid, .rsp_data, .cap_busy, .cap_overrun
    );

    task automatic expect_equal(input string what, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        a_value: assert (got === exp) else begin
            errors++;
            $display("Error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // FIFO chip model. A byte leaves the queue when rd_n rises.
    always @(negedge clk) begin
        if (rd_n && !rd_n_q && fifo_q.size() > 0)
            void'(fifo_q.pop_front());
        rd_n_q    = rd_n;
        rxf_n     = (fifo_q.size() == 0);
        fifo_data = (!rd_n && fifo_q.size() > 0) ? fifo_q[0] : 8'h00;
    end

    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            checks++;
            a_rsp_expected: assert (exp_q.size() > 0) else begin
                errors++;
                $display("a read response came that no read command asked for, at %0t ns",
                         $time);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                expect_equal("rsp_data", rsp_data, want);
            end
        end
    end

    a_overrun_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) cap_overrun |=> cap_overrun
    ) else begin
        errors++;
        $display("cap_overrun went low again after it had been set");
    end

    task automatic send_cmd(input logic [7:0] op, input logic [7:0] addr,
                            input logic [7:0] data);
        @(posedge clk);
        fifo_q.push_back(op);
        fifo_q.push_back(addr);
        fifo_q.push_back(data);
        if (op == op_write)
            ref_mem[addr] = data;
        else if (op == op_read)
            exp_q.push_back(ref_mem[addr]);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((fifo_q.size() > 0 || exp_q.size() > 0) && n < 3000) begin
            @(posedge clk);
            n++;
        end
        if (fifo_q.size() > 0 || exp_q.size() > 0) begin
            errors++;
            $display("timeout while waiting for the FIFO bytes and read responses");
        end
    endtask

    task automatic wait_busy(input logic level);
        int n;
        n = 0;
        while (cap_busy !== level && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (cap_busy !== level) begin
            errors++;
            $display("timeout while waiting for cap_busy to become %0d", level);
        end
    endtask

    task automatic strobe_sample(input logic [7:0] data, input int gap);
        @(negedge clk);
        sample_strobe = 1'b1;
        sample_data   = data;
        @(negedge clk);
        sample_strobe = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic end_test(input int num, input string name);
        if (errors > mark)
            failed_tests++;
        $display("test %0d %s: %0d errors", num, name, errors - mark);
        mark = errors;
    endtask

    initial begin
        logic [7:0] a;
        logic [7:0] d;
        rxf_n         = 1'b1;
        fifo_data     = 8'h00;
        sample_strobe = 1'b0;
        sample_data   = 8'h00;
        rd_n_q        = 1'b1;
        errors        = 0;
        checks        = 0;
        mark          = 0;
        failed_tests  = 0;
        void'($urandom(32'hfa6ad4ea));

        repeat (6) @(negedge clk);
        expect_equal("rd_n", rd_n, 1);
        expect_equal("rsp_valid", rsp_valid, 0);
        expect_equal("cap_busy", cap_busy, 0);
        expect_equal("cap_overrun", cap_overrun, 0);
        end_test(1, "reset values");

        for (int i = 0; i < 8; i++) begin
            a = 8'($urandom % 64);
            used_addr.push_back(a);
            send_cmd(op_write, a, 8'($urandom));
        end
        foreach (used_addr[i])
            send_cmd(op_read, used_addr[i], 8'h00);
        wait_drained();
        end_test(2, "write then read");

        send_cmd(8'h5a, used_addr[0], 8'hee); // not an opcode so the decoder drops it.
        send_cmd(op_read, used_addr[0], 8'h00);
        wait_drained();
        end_test(3, "unknown opcode");

        send_cmd(op_capture, 8'hfc, 8'd6); // wraps past the top address.
        wait_busy(1'b1);
        for (int i = 0; i < 6; i++) begin
            a = 8'hfc + 8'(i);
            d = 8'($urandom);
            ref_mem[a] = d;
            expect_equal("cap_busy", cap_busy, 1);
            strobe_sample(d, 7);
        end
        wait_busy(1'b0);
        expect_equal("cap_overrun", cap_overrun, 0);
        for (int i = 0; i < 6; i++)
            send_cmd(op_read, 8'hfc + 8'(i), 8'h00);
        wait_drained();
        end_test(4, "spaced capture");

        send_cmd(op_capture, 8'h80, 8'd40);
        wait_busy(1'b1);
        for (int i = 0; i < 6; i++) begin
            a = 8'($urandom % 64);
            send_cmd(op_write, a, 8'($urandom));
            send_cmd(op_read, a, 8'h00);
        end
        repeat (15) @(negedge clk);
        sample_strobe = 1'b1; // a burst that collides with decoder requests.
        for (int i = 0; i < 40; i++) begin
            sample_data = 8'($urandom);
            @(negedge clk);
        end
        sample_strobe = 1'b0;
        for (int i = 0; i < 8 && cap_busy; i++)
            strobe_sample(8'($urandom), 7);
        wait_busy(1'b0);
        wait_drained();
        expect_equal("cap_overrun", cap_overrun, 1);
        end_test(5, "capture overrun");

        used_addr.delete();
        for (int i = 0; i < 12; i++) begin
            a = 8'h40 + 8'($urandom % 64);
            if (i < 2 || i % 4 == 0) begin
                used_addr.push_back(a);
                send_cmd(op_write, a, 8'($urandom));
            end else begin
                send_cmd(op_read, used_addr[$urandom % used_addr.size()], 8'h00);
            end
        end
        wait_drained();
        end_test(6, "back-to-back bytes");

        $display("6 tests, %0d failed, %0d checks, %0d errors", failed_tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- usb_cmd_bridge.f
hdl/usb_bridge_pkg.sv
hdl/usb_fifo_rx.sv
hdl/cmd_decoder.sv
hdl/capture_engine.sv
hdl/mem_arbiter.sv
hdl/shared_ram.sv
hdl/usb_cmd_bridge.sv
bench/clk_gen.sv
bench/tb_usb_cmd_bridge.sv
